// File: mips_decode_pkg.sv
`default_nettype none

package mips_decode_pkg;

   localparam int NB_DATA  = 32;
   localparam int NB_REG   = 5;
   localparam int NB_FUNCT = 6;

   typedef logic [NB_DATA-1:0]  word_t;     // data, address or instruction
   typedef logic [NB_REG-1:0]   reg_idx_t;
   typedef logic [NB_FUNCT-1:0] funct_t;
   typedef logic [3:0]          alu_op_t;
   typedef logic [1:0]          src_a_t;
   typedef logic                src_b_t;
   typedef logic [1:0]          dest_sel_t;

   // alu operation codes, decoded further in execute
   localparam alu_op_t ALU_NONE = 4'd0;
   localparam alu_op_t ALU_ADD  = 4'd1;
   localparam alu_op_t ALU_SLT  = 4'd2;
   localparam alu_op_t ALU_AND  = 4'd3;
   localparam alu_op_t ALU_OR   = 4'd4;
   localparam alu_op_t ALU_XOR  = 4'd5;
   localparam alu_op_t ALU_LUI  = 4'd6;
   localparam alu_op_t ALU_JAL  = 4'd7;
   localparam alu_op_t ALU_FUNC = 4'd8;   // look at funct field

   localparam src_a_t SRC_A_PC    = 2'd0;
   localparam src_a_t SRC_A_RS    = 2'd1;
   localparam src_a_t SRC_A_SHAMT = 2'd2;
   localparam src_a_t SRC_A_NONE  = 2'd3;

   localparam src_b_t SRC_B_RT  = 1'b0;
   localparam src_b_t SRC_B_IMM = 1'b1;

   localparam dest_sel_t DEST_RD = 2'd0;
   localparam dest_sel_t DEST_RT = 2'd1;
   localparam dest_sel_t DEST_RA = 2'd2;   // r31 for jal

   // primary opcodes, instr[31:26]
   localparam logic [5:0] OP_SPECIAL = 6'h00;
   localparam logic [5:0] OP_J       = 6'h02;
   localparam logic [5:0] OP_JAL     = 6'h03;
   localparam logic [5:0] OP_BEQ     = 6'h04;
   localparam logic [5:0] OP_BNE     = 6'h05;
   localparam logic [5:0] OP_ADDI    = 6'h08;
   localparam logic [5:0] OP_SLTI    = 6'h0A;
   localparam logic [5:0] OP_ANDI    = 6'h0C;
   localparam logic [5:0] OP_ORI     = 6'h0D;
   localparam logic [5:0] OP_XORI    = 6'h0E;
   localparam logic [5:0] OP_LUI     = 6'h0F;
   localparam logic [5:0] OP_LW      = 6'h23;
   localparam logic [5:0] OP_LWU     = 6'h27;
   localparam logic [5:0] OP_SW      = 6'h2B;

   // special funct codes, instr[5:0]
   localparam funct_t FN_SLL  = 6'h00;
   localparam funct_t FN_SRL  = 6'h02;
   localparam funct_t FN_SRA  = 6'h03;
   localparam funct_t FN_JR   = 6'h08;
   localparam funct_t FN_JALR = 6'h09;

endpackage

`default_nettype wire

// File: decode_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module decode_ctrl (
   input  wire mips_decode_pkg::word_t i_instr,
   output mips_decode_pkg::alu_op_t    o_alu_op,
   output mips_decode_pkg::src_a_t     o_src_a,
   output mips_decode_pkg::src_b_t     o_src_b,
   output mips_decode_pkg::dest_sel_t  o_dest_sel,
   output logic                        o_mem_rd,
   output logic                        o_mem_wr,
   output logic                        o_wb_from_mem,
   output logic                        o_wb_en,
   output logic                        o_is_beq,
   output logic                        o_is_bne,
   output logic                        o_is_jump,
   output logic                        o_jump_reg,
   output mips_decode_pkg::word_t      o_imm
);
   import mips_decode_pkg::*;

   // immediate extension modes
   localparam logic [1:0] EXT_SIGN  = 2'd0;
   localparam logic [1:0] EXT_ZERO  = 2'd1;
   localparam logic [1:0] EXT_JUMP  = 2'd2;
   localparam logic [1:0] EXT_SHAMT = 2'd3;

   logic [5:0] opcode;
   funct_t     funct;
   logic [1:0] ext_mode;
   logic       is_jr_jalr;

   assign opcode     = i_instr[31:26];
   assign funct      = i_instr[5:0];
   assign is_jr_jalr = (funct == FN_JR) || (funct == FN_JALR);

   always_comb begin
      // defaults, also for unknown opcodes
      ext_mode      = EXT_SIGN;
      o_alu_op      = ALU_NONE;
      o_src_a       = SRC_A_NONE;
      o_src_b       = SRC_B_IMM;
      o_dest_sel    = DEST_RD;
      o_mem_rd      = 1'b0;
      o_mem_wr      = 1'b0;
      o_wb_from_mem = 1'b0;
      o_wb_en       = 1'b0;
      o_is_beq      = 1'b0;
      o_is_bne      = 1'b0;
      o_is_jump     = 1'b0;
      o_jump_reg    = 1'b0;
      case (opcode)
         OP_J: begin
            ext_mode  = EXT_JUMP;
            o_is_jump = 1'b1;
         end
         OP_JAL: begin
            ext_mode   = EXT_JUMP;
            o_alu_op   = ALU_JAL;
            o_src_a    = SRC_A_PC;     // return address built in execute
            o_dest_sel = DEST_RA;
            o_is_jump  = 1'b1;
            o_wb_en    = 1'b1;
         end
         OP_BEQ: o_is_beq = 1'b1;
         OP_BNE: o_is_bne = 1'b1;
         OP_ADDI, OP_SLTI: begin
            o_alu_op   = (opcode == OP_ADDI) ? ALU_ADD : ALU_SLT;
            o_src_a    = SRC_A_RS;
            o_dest_sel = DEST_RT;
            o_wb_en    = 1'b1;
         end
         OP_ANDI, OP_ORI, OP_XORI: begin
            ext_mode   = EXT_ZERO;   // logical ops take unsigned imm
            o_alu_op   = (opcode == OP_ANDI) ? ALU_AND :
                         (opcode == OP_ORI)  ? ALU_OR  : ALU_XOR;
            o_src_a    = SRC_A_RS;
            o_dest_sel = DEST_RT;
            o_wb_en    = 1'b1;
         end
         OP_LUI: begin
            ext_mode   = EXT_ZERO;
            o_alu_op   = ALU_LUI;
            o_dest_sel = DEST_RT;
            o_wb_en    = 1'b1;
         end
         OP_LW, OP_LWU: begin
            o_alu_op      = ALU_ADD;   // base + offset
            o_src_a       = SRC_A_RS;
            o_dest_sel    = DEST_RT;
            o_mem_rd      = 1'b1;
            o_wb_from_mem = 1'b1;
            o_wb_en       = 1'b1;
         end
         OP_SW: begin
            o_alu_op   = ALU_ADD;
            o_src_a    = SRC_A_RS;
            o_dest_sel = DEST_RT;
            o_mem_wr   = 1'b1;
         end
         OP_SPECIAL: begin
            ext_mode = EXT_SHAMT;
            o_alu_op = ALU_FUNC;
            o_src_b  = SRC_B_RT;
            case (funct)
               FN_JALR:                o_src_a = SRC_A_PC;
               FN_SLL, FN_SRL, FN_SRA: o_src_a = SRC_A_SHAMT;
               default:                o_src_a = SRC_A_RS;
            endcase
            o_is_jump  = is_jr_jalr;
            o_jump_reg = is_jr_jalr;
            // jr writes nothing, all-zero word is a nop
            o_wb_en    = !((funct == FN_JR) || (i_instr == '0));
         end
         default: ;
      endcase
   end

   always_comb begin
      case (ext_mode)
         EXT_JUMP:  o_imm = {6'b0, i_instr[25:0]};
         EXT_ZERO:  o_imm = {16'b0, i_instr[15:0]};
         EXT_SHAMT: o_imm = {27'b0, i_instr[10:6]};
         default:   o_imm = {{16{i_instr[15]}}, i_instr[15:0]};
      endcase
   end

   always_comb begin
      assert (!(o_mem_rd && o_mem_wr)) else $error("decode_ctrl: read and write together");
      assert (!(o_is_beq && o_is_bne)) else $error("decode_ctrl: beq and bne together");
   end

endmodule

`default_nettype wire

// File: register_file.sv
`timescale 1ns/100ps
`default_nettype none

module register_file (
   input  wire                            i_clk,
   input  wire                            i_rst,
   input  wire mips_decode_pkg::reg_idx_t i_rs_addr,
   input  wire mips_decode_pkg::reg_idx_t i_rt_addr,
   input  wire mips_decode_pkg::reg_idx_t i_wr_addr,
   input  wire mips_decode_pkg::word_t    i_wr_data,
   input  wire                            i_wr_en,
   output mips_decode_pkg::word_t         o_rs_val,
   output mips_decode_pkg::word_t         o_rt_val,
   output logic                           o_rs_eq_rt
);
   import mips_decode_pkg::*;

   localparam int NUM_REGS = 2 ** NB_REG;

   word_t regs [NUM_REGS];

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (i_wr_en && (i_wr_addr != '0)) begin   // r0 stays zero
         regs[i_wr_addr] <= i_wr_data;
      end
   end

   // async reads, same-cycle write not bypassed
   assign o_rs_val   = regs[i_rs_addr];
   assign o_rt_val   = regs[i_rt_addr];
   assign o_rs_eq_rt = (o_rs_val == o_rt_val);   // for beq/bne

   a_r0_zero : assert property (@(posedge i_clk) disable iff (i_rst)
      (i_wr_en && (i_wr_addr == '0)) |=> (regs[0] == '0))
      else $error("register_file: r0 changed after write");

endmodule

`default_nettype wire

// File: branch_resolve.sv
`timescale 1ns/100ps
`default_nettype none

module branch_resolve (
   input  wire mips_decode_pkg::word_t i_pc,
   input  wire mips_decode_pkg::word_t i_imm,
   input  wire mips_decode_pkg::word_t i_rs_val,
   input  wire [25:0]                  i_instr_index,
   input  wire                         i_is_beq,
   input  wire                         i_is_bne,
   input  wire                         i_is_jump,
   input  wire                         i_jump_reg,
   input  wire                         i_rs_eq_rt,
   output logic                        o_branch_taken,
   output logic                        o_jump,
   output mips_decode_pkg::word_t      o_brh_addr,
   output mips_decode_pkg::word_t      o_jmp_addr
);
   import mips_decode_pkg::*;

   word_t region_addr;

   assign o_branch_taken = (i_is_beq && i_rs_eq_rt) || (i_is_bne && !i_rs_eq_rt);
   assign o_jump         = i_is_jump;

   // word offset, relative to the branch pc
   assign o_brh_addr = i_pc + (i_imm << 2);

   // j/jal stay inside the current 256 MB region
   assign region_addr = {i_pc[NB_DATA-1 -: 4], i_instr_index, 2'b00};
   assign o_jmp_addr  = i_jump_reg ? i_rs_val : region_addr;   // jr/jalr

   // flags come from decode_ctrl, equality from register_file
   always_comb begin
      assert (!(o_branch_taken && o_jump))
         else $error("branch_resolve: branch and jump in the same cycle");
   end

endmodule

`default_nettype wire

// File: id_ex_reg.sv
`timescale 1ns/100ps
`default_nettype none

module id_ex_reg (
   input  wire                             i_clk,
   input  wire                             i_rst,
   input  wire mips_decode_pkg::word_t     i_pc,
   input  wire mips_decode_pkg::word_t     i_rs_val,
   input  wire mips_decode_pkg::word_t     i_rt_val,
   input  wire mips_decode_pkg::word_t     i_imm,
   input  wire mips_decode_pkg::funct_t    i_funct,
   input  wire mips_decode_pkg::reg_idx_t  i_rt_num,
   input  wire mips_decode_pkg::reg_idx_t  i_rd_num,
   input  wire mips_decode_pkg::alu_op_t   i_alu_op,
   input  wire mips_decode_pkg::src_a_t    i_src_a,
   input  wire mips_decode_pkg::src_b_t    i_src_b,
   input  wire mips_decode_pkg::dest_sel_t i_dest_sel,
   input  wire                             i_mem_rd,
   input  wire                             i_mem_wr,
   input  wire                             i_wb_from_mem,
   input  wire                             i_wb_en,
   output mips_decode_pkg::word_t          o_ex_pc,
   output mips_decode_pkg::word_t          o_ex_rs_val,
   output mips_decode_pkg::word_t          o_ex_rt_val,
   output mips_decode_pkg::word_t          o_ex_imm,
   output mips_decode_pkg::funct_t         o_ex_funct,
   output mips_decode_pkg::reg_idx_t       o_ex_rt_num,
   output mips_decode_pkg::reg_idx_t       o_ex_rd_num,
   output mips_decode_pkg::alu_op_t        o_ex_alu_op,
   output mips_decode_pkg::src_a_t         o_ex_src_a,
   output mips_decode_pkg::src_b_t         o_ex_src_b,
   output mips_decode_pkg::dest_sel_t      o_ex_dest_sel,
   output logic                            o_ex_mem_rd,
   output logic                            o_ex_mem_wr,
   output logic                            o_ex_wb_from_mem,
   output logic                            o_ex_wb_en
);
   import mips_decode_pkg::*;

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_ex_pc          <= '0;
         o_ex_rs_val      <= '0;
         o_ex_rt_val      <= '0;
         o_ex_imm         <= '0;
         o_ex_funct       <= '0;
         o_ex_rt_num      <= '0;
         o_ex_rd_num      <= '0;
         o_ex_alu_op      <= ALU_NONE;   // all zero-valued codes
         o_ex_src_a       <= SRC_A_PC;
         o_ex_src_b       <= SRC_B_RT;
         o_ex_dest_sel    <= DEST_RD;
         o_ex_mem_rd      <= 1'b0;
         o_ex_mem_wr      <= 1'b0;
         o_ex_wb_from_mem <= 1'b0;
         o_ex_wb_en       <= 1'b0;
      end else begin
         o_ex_pc          <= i_pc;
         o_ex_rs_val      <= i_rs_val;
         o_ex_rt_val      <= i_rt_val;
         o_ex_imm         <= i_imm;
         o_ex_funct       <= i_funct;
         o_ex_rt_num      <= i_rt_num;
         o_ex_rd_num      <= i_rd_num;
         o_ex_alu_op      <= i_alu_op;
         o_ex_src_a       <= i_src_a;
         o_ex_src_b       <= i_src_b;
         o_ex_dest_sel    <= i_dest_sel;
         o_ex_mem_rd      <= i_mem_rd;
         o_ex_mem_wr      <= i_mem_wr;
         o_ex_wb_from_mem <= i_wb_from_mem;
         o_ex_wb_en       <= i_wb_en;
      end
   end

   // nothing may commit in the first cycle out of reset
   a_quiet_after_rst : assert property (@(posedge i_clk)
      ($past(i_rst) && !i_rst) |-> (!o_ex_wb_en && !o_ex_mem_wr))
      else $error("id_ex_reg: side effect right after reset");

endmodule

`default_nettype wire

// File: decode_stage.sv
`timescale 1ns/100ps
`default_nettype none

module decode_stage (
   input  wire                            i_clk,
   input  wire                            i_rst,
   input  wire mips_decode_pkg::word_t    i_pc,
   input  wire mips_decode_pkg::word_t    i_instr,
   input  wire mips_decode_pkg::word_t    i_wb_data,
   input  wire mips_decode_pkg::reg_idx_t i_wb_addr,
   input  wire                            i_wb_en,
   output mips_decode_pkg::word_t         o_ex_pc,
   output mips_decode_pkg::word_t         o_ex_rs_val,
   output mips_decode_pkg::word_t         o_ex_rt_val,
   output mips_decode_pkg::word_t         o_ex_imm,
   output mips_decode_pkg::funct_t        o_ex_funct,
   output mips_decode_pkg::reg_idx_t      o_ex_rt_num,
   output mips_decode_pkg::reg_idx_t      o_ex_rd_num,
   output mips_decode_pkg::alu_op_t       o_ex_alu_op,
   output mips_decode_pkg::src_a_t        o_ex_src_a,
   output mips_decode_pkg::src_b_t        o_ex_src_b,
   output mips_decode_pkg::dest_sel_t     o_ex_dest_sel,
   output logic                           o_ex_mem_rd,
   output logic                           o_ex_mem_wr,
   output logic                           o_ex_wb_from_mem,
   output logic                           o_ex_wb_en,
   output logic                           o_branch_taken,
   output logic                           o_jump,
   output mips_decode_pkg::word_t         o_brh_addr,
   output mips_decode_pkg::word_t         o_jmp_addr
);
   import mips_decode_pkg::*;

   // decoded control
   alu_op_t   alu_op;
   src_a_t    src_a;
   src_b_t    src_b;
   dest_sel_t dest_sel;
   logic      mem_rd;
   logic      mem_wr;
   logic      wb_from_mem;
   logic      wb_en;
   logic      is_beq;
   logic      is_bne;
   logic      is_jump;
   logic      jump_reg;
   word_t     imm;
   // register file
   word_t     rs_val;
   word_t     rt_val;
   logic      rs_eq_rt;

   decode_ctrl u_decode_ctrl (
      .i_instr       (i_instr),
      .o_alu_op      (alu_op),
      .o_src_a       (src_a),
      .o_src_b       (src_b),
      .o_dest_sel    (dest_sel),
      .o_mem_rd      (mem_rd),
      .o_mem_wr      (mem_wr),
      .o_wb_from_mem (wb_from_mem),
      .o_wb_en       (wb_en),
      .o_is_beq      (is_beq),
      .o_is_bne      (is_bne),
      .o_is_jump     (is_jump),
      .o_jump_reg    (jump_reg),
      .o_imm         (imm)
   );

   register_file u_register_file (
      .i_clk      (i_clk),
      .i_rst      (i_rst),
      .i_rs_addr  (i_instr[25:21]),
      .i_rt_addr  (i_instr[20:16]),
      .i_wr_addr  (i_wb_addr),      // from write-back stage
      .i_wr_data  (i_wb_data),
      .i_wr_en    (i_wb_en),
      .o_rs_val   (rs_val),
      .o_rt_val   (rt_val),
      .o_rs_eq_rt (rs_eq_rt)
   );

   branch_resolve u_branch_resolve (
      .i_pc           (i_pc),
      .i_imm          (imm),
      .i_rs_val       (rs_val),
      .i_instr_index  (i_instr[25:0]),
      .i_is_beq       (is_beq),
      .i_is_bne       (is_bne),
      .i_is_jump      (is_jump),
      .i_jump_reg     (jump_reg),
      .i_rs_eq_rt     (rs_eq_rt),
      .o_branch_taken (o_branch_taken),
      .o_jump         (o_jump),
      .o_brh_addr     (o_brh_addr),
      .o_jmp_addr     (o_jmp_addr)
   );

   id_ex_reg u_id_ex_reg (
      .i_clk            (i_clk),
      .i_rst            (i_rst),
      .i_pc             (i_pc),
      .i_rs_val         (rs_val),
      .i_rt_val         (rt_val),
      .i_imm            (imm),
      .i_funct          (i_instr[5:0]),
      .i_rt_num         (i_instr[20:16]),
      .i_rd_num         (i_instr[15:11]),
      .i_alu_op         (alu_op),
      .i_src_a          (src_a),
      .i_src_b          (src_b),
      .i_dest_sel       (dest_sel),
      .i_mem_rd         (mem_rd),
      .i_mem_wr         (mem_wr),
      .i_wb_from_mem    (wb_from_mem),
      .i_wb_en          (wb_en),
      .o_ex_pc          (o_ex_pc),
      .o_ex_rs_val      (o_ex_rs_val),
      .o_ex_rt_val      (o_ex_rt_val),
      .o_ex_imm         (o_ex_imm),
      .o_ex_funct       (o_ex_funct),
      .o_ex_rt_num      (o_ex_rt_num),
      .o_ex_rd_num      (o_ex_rd_num),
      .o_ex_alu_op      (o_ex_alu_op),
      .o_ex_src_a       (o_ex_src_a),
      .o_ex_src_b       (o_ex_src_b),
      .o_ex_dest_sel    (o_ex_dest_sel),
      .o_ex_mem_rd      (o_ex_mem_rd),
      .o_ex_mem_wr      (o_ex_mem_wr),
      .o_ex_wb_from_mem (o_ex_wb_from_mem),
      .o_ex_wb_en       (o_ex_wb_en)
   );

endmodule

`default_nettype wire

// File: tb_decode_stage.sv
`timescale 1ns/100ps
`default_nettype none

module tb_decode_stage;
   import mips_decode_pkg::*;

   localparam int CLK_PERIOD = 40;
   localparam int DRIVE_DLY  = 2;   // after the rising edge
   localparam logic [5:0] OP_LIST [14] = '{OP_SPECIAL, OP_J, OP_JAL, OP_BEQ, OP_BNE,
      OP_ADDI, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI, OP_LW, OP_LWU, OP_SW};
   localparam funct_t FN_LIST [5] = '{FN_SLL, FN_SRL, FN_SRA, FN_JR, FN_JALR};

   typedef struct packed {
      alu_op_t   alu_op;
      src_a_t    src_a;
      src_b_t    src_b;
      dest_sel_t dest_sel;
      logic      mem_rd;
      logic      mem_wr;
      logic      wb_from_mem;
      logic      wb_en;
      word_t     imm;
   } ctrl_t;

   logic      i_clk;
   logic      i_rst;
   word_t     i_pc;
   word_t     i_instr;
   word_t     i_wb_data;
   reg_idx_t  i_wb_addr;
   logic      i_wb_en;
   word_t     o_ex_pc, o_ex_rs_val, o_ex_rt_val, o_ex_imm;
   funct_t    o_ex_funct;
   reg_idx_t  o_ex_rt_num, o_ex_rd_num;
   alu_op_t   o_ex_alu_op;
   src_a_t    o_ex_src_a;
   src_b_t    o_ex_src_b;
   dest_sel_t o_ex_dest_sel;
   logic      o_ex_mem_rd, o_ex_mem_wr, o_ex_wb_from_mem, o_ex_wb_en;
   logic      o_branch_taken, o_jump;
   word_t     o_brh_addr, o_jmp_addr;

   integer    seed;
   word_t     model [32];   // reference register contents
   ctrl_t     exp_ctrl;     // decoded last cycle, due at the next edge
   word_t     exp_pc, exp_rs, exp_rt, exp_instr;
   logic      exp_valid;
   int        n_checked;

   decode_stage u_dut (.*);

   initial begin
      i_clk = 1'b0;
      forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
   end

   function automatic word_t rand_word();
      rand_word = $random(seed);
   endfunction

   // expected control fields straight from the decode table
   function automatic ctrl_t expected_ctrl(input word_t instr);
      ctrl_t      c;
      logic [5:0] op;
      funct_t     fn;
      op = instr[31:26];
      fn = instr[5:0];
      c = '0;
      c.src_a    = SRC_A_NONE;
      c.src_b    = SRC_B_IMM;
      c.dest_sel = DEST_RD;
      case (op)
         OP_ADDI, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI, OP_LW, OP_LWU, OP_SW: begin
            c.dest_sel = DEST_RT;
            c.src_a    = (op == OP_LUI) ? SRC_A_NONE : SRC_A_RS;
            c.wb_en    = (op != OP_SW);
         end
         OP_JAL: begin
            c.src_a    = SRC_A_PC;
            c.dest_sel = DEST_RA;
            c.wb_en    = 1'b1;
         end
         OP_SPECIAL: begin
            c.src_b = SRC_B_RT;
            if (fn == FN_JALR) c.src_a = SRC_A_PC;
            else if (fn inside {FN_SLL, FN_SRL, FN_SRA}) c.src_a = SRC_A_SHAMT;
            else c.src_a = SRC_A_RS;
            c.wb_en = (fn != FN_JR) && (instr != '0);   // jr and nop write nothing
         end
         default: ;
      endcase
      case (op)
         OP_ADDI, OP_LW, OP_LWU, OP_SW: c.alu_op = ALU_ADD;
         OP_SLTI:    c.alu_op = ALU_SLT;
         OP_ANDI:    c.alu_op = ALU_AND;
         OP_ORI:     c.alu_op = ALU_OR;
         OP_XORI:    c.alu_op = ALU_XOR;
         OP_LUI:     c.alu_op = ALU_LUI;
         OP_JAL:     c.alu_op = ALU_JAL;
         OP_SPECIAL: c.alu_op = ALU_FUNC;
         default:    c.alu_op = ALU_NONE;
      endcase
      c.mem_rd      = (op == OP_LW) || (op == OP_LWU);
      c.wb_from_mem = c.mem_rd;
      c.mem_wr      = (op == OP_SW);
      if ((op == OP_J) || (op == OP_JAL)) c.imm = {6'b0, instr[25:0]};
      else if (op inside {OP_ANDI, OP_ORI, OP_XORI, OP_LUI}) c.imm = {16'b0, instr[15:0]};
      else if (op == OP_SPECIAL) c.imm = {27'b0, instr[10:6]};
      else c.imm = {{16{instr[15]}}, instr[15:0]};
      return c;
   endfunction

   task automatic check_value(input string name, input word_t actual, input word_t expected);
      if (actual !== expected) begin
         $display("FAILED %s: got %h, expected %h", name, actual, expected);
         $display(">>> FAIL");
         $fatal(1, "value mismatch on %s", name);
      end
   endtask

   task automatic verify_ex_outputs();
      check_value("o_ex_pc", o_ex_pc, exp_pc);
      check_value("o_ex_rs_val", o_ex_rs_val, exp_rs);
      check_value("o_ex_rt_val", o_ex_rt_val, exp_rt);
      check_value("o_ex_imm", o_ex_imm, exp_ctrl.imm);
      check_value("o_ex_funct", 32'(o_ex_funct), 32'(exp_instr[5:0]));
      check_value("o_ex_rt_num", 32'(o_ex_rt_num), 32'(exp_instr[20:16]));
      check_value("o_ex_rd_num", 32'(o_ex_rd_num), 32'(exp_instr[15:11]));
      check_value("o_ex_alu_op", 32'(o_ex_alu_op), 32'(exp_ctrl.alu_op));
      check_value("o_ex_src_a", 32'(o_ex_src_a), 32'(exp_ctrl.src_a));
      check_value("o_ex_src_b", 32'(o_ex_src_b), 32'(exp_ctrl.src_b));
      check_value("o_ex_dest_sel", 32'(o_ex_dest_sel), 32'(exp_ctrl.dest_sel));
      check_value("o_ex_mem_rd", 32'(o_ex_mem_rd), 32'(exp_ctrl.mem_rd));
      check_value("o_ex_mem_wr", 32'(o_ex_mem_wr), 32'(exp_ctrl.mem_wr));
      check_value("o_ex_wb_from_mem", 32'(o_ex_wb_from_mem), 32'(exp_ctrl.wb_from_mem));
      check_value("o_ex_wb_en", 32'(o_ex_wb_en), 32'(exp_ctrl.wb_en));
   endtask

   // same-cycle branch and jump outputs
   task automatic inspect_branch_jump(input word_t instr, input word_t pc, input word_t rs_v,
                                      input word_t rt_v, input word_t imm);
      logic [5:0] op;
      logic       is_jr;
      logic       taken;
      logic       jump;
      word_t      jaddr;
      op     = instr[31:26];
      is_jr  = (op == OP_SPECIAL) && ((instr[5:0] == FN_JR) || (instr[5:0] == FN_JALR));
      taken  = ((op == OP_BEQ) && (rs_v == rt_v)) || ((op == OP_BNE) && (rs_v != rt_v));
      jump   = is_jr || (op == OP_J) || (op == OP_JAL);
      jaddr  = is_jr ? rs_v : {pc[31:28], instr[25:0], 2'b00};
      check_value("o_branch_taken", 32'(o_branch_taken), 32'(taken));
      check_value("o_jump", 32'(o_jump), 32'(jump));
      check_value("o_brh_addr", o_brh_addr, pc + (imm << 2));
      check_value("o_jmp_addr", o_jmp_addr, jaddr);
   endtask

   // comparison process, registered outputs after the edge, the rest just before it
   initial begin
      ctrl_t cur;
      word_t rs_m;
      word_t rt_m;
      exp_valid = 1'b0;
      n_checked = 0;
      forever begin
         @(posedge i_clk);
         #1;
         if (exp_valid) begin
            verify_ex_outputs();
            n_checked++;
         end
         #(CLK_PERIOD - 3);
         if (i_rst) begin
            for (int k = 0; k < 32; k++) model[k] = '0;
            exp_ctrl  = '0;   // reset loads zeros
            exp_pc    = '0;
            exp_rs    = '0;
            exp_rt    = '0;
            exp_instr = '0;
         end else begin
            cur  = expected_ctrl(i_instr);
            rs_m = model[i_instr[25:21]];
            rt_m = model[i_instr[20:16]];
            inspect_branch_jump(i_instr, i_pc, rs_m, rt_m, cur.imm);
            exp_ctrl  = cur;
            exp_pc    = i_pc;
            exp_rs    = rs_m;   // old value even when written this cycle
            exp_rt    = rt_m;
            exp_instr = i_instr;
            if (i_wb_en && (i_wb_addr != '0)) model[i_wb_addr] = i_wb_data;
         end
         exp_valid = 1'b1;
      end
   end

   task automatic drive_cycle(input word_t instr, input logic wb_en, input reg_idx_t wb_addr,
                              input word_t wb_data);
      word_t pc_r;
      pc_r = rand_word();
      @(posedge i_clk);
      #DRIVE_DLY;
      i_instr   = instr;
      i_pc      = {pc_r[31:2], 2'b00};
      i_wb_en   = wb_en;
      i_wb_addr = wb_addr;
      i_wb_data = wb_data;
   endtask

   task automatic wait_for_checks(input int target);
      int cycles;
      cycles = 0;
      while (n_checked < target) begin
         @(posedge i_clk);
         cycles++;
         if (cycles > 10) begin
            $display("timeout: comparison process did not reach %0d checks", target);
            $display(">>> FAIL");
            $fatal(1, "comparison process stalled");
         end
      end
   endtask

   initial begin
      word_t r;
      word_t wb;
      int    sel;
      seed      = 70378;
      i_rst     = 1'b1;
      i_pc      = '0;
      i_instr   = '0;
      i_wb_data = '0;
      i_wb_addr = '0;
      i_wb_en   = 1'b0;
      repeat (8) @(posedge i_clk);
      #DRIVE_DLY;
      i_rst   = 1'b0;
      i_instr = {OP_LW, 26'h0};   // first instruction out of reset
      wait_for_checks(7);
      // fill every register, r0 included, then read them back
      for (int k = 0; k < 32; k++) drive_cycle('0, 1'b1, 5'(k), rand_word());
      for (int k = 0; k < 32; k++) begin
         drive_cycle({OP_SPECIAL, 5'(k), 5'(31 - k), 10'd0, 6'h20}, 1'b0, '0, '0);
      end
      // every kept opcode with random fields
      for (int k = 0; k < 14; k++) begin
         r = rand_word();
         if (OP_LIST[k] == OP_SPECIAL) begin
            for (int f = 0; f < 5; f++) begin
               drive_cycle({OP_SPECIAL, r[25:6], FN_LIST[f]}, 1'b0, '0, '0);
            end
            r[5] = 1'b1;   // funct off the listed codes
         end
         drive_cycle({OP_LIST[k], r[25:0]}, 1'b0, '0, '0);
      end
      // branches, r5 equals r7 and differs from r6
      drive_cycle('0, 1'b1, 5'd5, 32'h1234_5678);
      drive_cycle('0, 1'b1, 5'd6, 32'h0BAD_F00D);
      drive_cycle('0, 1'b1, 5'd7, 32'h1234_5678);
      for (int b = 0; b < 2; b++) begin
         r = rand_word();
         drive_cycle({b ? OP_BNE : OP_BEQ, 5'd5, 5'd5, r[15:0]}, 1'b0, '0, '0);
         drive_cycle({b ? OP_BNE : OP_BEQ, 5'd5, 5'd7, r[31:16]}, 1'b0, '0, '0);
         drive_cycle({b ? OP_BNE : OP_BEQ, 5'd5, 5'd6, r[15:0]}, 1'b0, '0, '0);
      end
      // random mix with interleaved writes
      repeat (500) begin
         r   = rand_word();
         wb  = rand_word();
         sel = int'(r[31:24]) % 15;
         if (sel == 14) drive_cycle(r, wb[31], wb[4:0], rand_word());   // any opcode
         else drive_cycle({OP_LIST[sel], r[25:0]}, wb[31], wb[4:0], rand_word());
      end
      wait_for_checks(n_checked + 2);
      $display(">>> PASS");
      $finish;
   end

endmodule

`default_nettype wire

// File: list.f
mips_decode_pkg.sv
decode_ctrl.sv
register_file.sv
branch_resolve.sv
id_ex_reg.sv
decode_stage.sv
tb_decode_stage.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f list.f --top-module tb_decode_stage -o sim_decode &&
./obj_dir/sim_decode ||
{ echo "decode stage simulation did not complete successfully"; exit 1; }
